// ==== Makefile ====
# Verilator build and run of the pad logic testbench
TOP := tb_fpga_pad_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f fpga_pad_top.f -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -qx "Verification passed" sim.log

lint:
	verilator --lint-only -Wall --top-module fpga_pad_top -f fpga_pad_top.f

clean:
	rm -rf obj_dir sim.log

// ==== bench/pad_checker.sv ====
// ************************************************************
// Reference model for the pad logic. Selects follow observed
// writes; bus, pads and LEDs are compared on every clock edge.
// ************************************************************

`timescale 1ns/1ps

module pad_checker
  import pad_pkg::*;
  import reg_bus_pkg::*;
#(
  parameter int HEARTBEAT_WIDTH = 27,
  parameter int RST_SYNC_STAGES = 2
) (
  input logic      clk_gen,
  input logic      rst_n,
  input logic      reg_valid_i,
  input logic      reg_write_i,
  input reg_addr_t reg_addr_i,
  input reg_data_t reg_wdata_i,
  input reg_data_t reg_rdata_i,
  input logic      reg_ready_i,
  input logic      reg_error_i,
  input pad_vec_t  periph_out_i,
  input pad_vec_t  periph_oe_i,
  input pad_vec_t  gpio_out_i,
  input pad_vec_t  gpio_oe_i,
  input pad_vec_t  pad_in_i,
  input pad_vec_t  pad_out_i,
  input pad_vec_t  pad_oe_i,
  input pad_vec_t  periph_in_i,
  input pad_vec_t  gpio_in_i,
  input logic      clk_led_i,
  input logic      rst_led_i
);

  pad_mux_sel_t sel_model [NUM_MUX_PADS];
  string        cur_name = "reset_release";
  reg_data_t    cur_exp  = '0;
  string        first_msg;
  int           cur_errs = 0;
  int           n_pass   = 0;
  int           n_fail   = 0;
  int           rel_cycles;
  int           valid_run;
  logic         ready_prev;

  task note_value(input string what, input reg_data_t exp, input reg_data_t act);
    if (exp !== act) begin
      if (cur_errs == 0) begin
        first_msg = $sformatf("FAILED %s: %s expected %0h actual %0h",
                              cur_name, what, exp, act);
      end
      cur_errs++;
    end
  endtask

  task note_text(input string msg);
    if (cur_errs == 0) begin
      first_msg = $sformatf("Test %s went wrong: %s", cur_name, msg);
    end
    cur_errs++;
  endtask

  task start_test(input string name, input reg_data_t exp);
    cur_name = name;
    cur_exp  = exp;
    cur_errs = 0;
  endtask

  task finish_test();
    if (cur_errs == 0) begin
      n_pass++;
      $display("PASS   %s", cur_name);
    end else begin
      n_fail++;
      $display("%s", first_msg);
    end
  endtask

  task report_counts(output int fails);
    $display("Tests run: %0d, passed: %0d, failed: %0d", n_pass + n_fail, n_pass, n_fail);
    fails = n_fail;
  endtask

  always @(posedge clk_gen) begin
    int       idx;
    int       hb;
    logic     exp_err;
    pad_vec_t gpio_sel;
    if (!rst_n) begin
      rel_cycles = 0;
      valid_run  = 0;
      ready_prev = 1'b0;
      for (int k = 0; k < NUM_MUX_PADS; k++) begin
        sel_model[k] = PAD_FUNC_PERIPH;
      end
      note_value("rst_led_o", '0, reg_data_t'(rst_led_i));
      note_value("clk_led_o", '0, reg_data_t'(clk_led_i));
    end else begin
      rel_cycles++;
      // Counter starts one edge after the synchronized release
      hb = rel_cycles - RST_SYNC_STAGES - 1;
      note_value("rst_led_o", reg_data_t'(rel_cycles > RST_SYNC_STAGES),
                 reg_data_t'(rst_led_i));
      note_value("clk_led_o",
                 reg_data_t'(hb >= 0 && ((hb / (2 ** (HEARTBEAT_WIDTH - 1))) % 2) == 1),
                 reg_data_t'(clk_led_i));
      if (reg_ready_i) begin
        idx     = reg_addr_i / REG_STRIDE;
        exp_err = ((reg_addr_i % REG_STRIDE) != 0) || (idx >= NUM_MUX_PADS);
        if (ready_prev) begin
          note_text("ready stayed high for two cycles");
        end
        if (valid_run != 1) begin
          note_text($sformatf("ready came %0d cycles after valid instead of 1", valid_run));
        end
        if (reg_write_i) begin
          note_value("reg_error_o", cur_exp, reg_data_t'(reg_error_i));
          if (!exp_err) begin
            sel_model[idx] = reg_wdata_i[PAD_SEL_W-1:0];
          end
        end else begin
          note_value("reg_error_o", reg_data_t'(exp_err), reg_data_t'(reg_error_i));
          note_value("reg_rdata_o", cur_exp, reg_rdata_i);
        end
      end else begin
        // Error only comes with ready
        note_value("reg_error_o", '0, reg_data_t'(reg_error_i));
      end
      valid_run  = (reg_valid_i && !reg_ready_i) ? valid_run + 1 : 0;
      ready_prev = reg_ready_i;
    end
    // Only code 1 hands a pad to the GPIO
    for (int k = 0; k < NUM_MUX_PADS; k++) begin
      gpio_sel[k] = (sel_model[k] == PAD_FUNC_GPIO);
    end
    note_value("pad_out_o", reg_data_t'((gpio_out_i & gpio_sel) | (periph_out_i & ~gpio_sel)),
               reg_data_t'(pad_out_i));
    note_value("pad_oe_o", reg_data_t'((gpio_oe_i & gpio_sel) | (periph_oe_i & ~gpio_sel)),
               reg_data_t'(pad_oe_i));
    note_value("gpio_in_o", reg_data_t'(pad_in_i & gpio_sel), reg_data_t'(gpio_in_i));
    note_value("periph_in_o", reg_data_t'(pad_in_i & ~gpio_sel), reg_data_t'(periph_in_i));
  end

endmodule

// ==== bench/pad_patterns.txt ====
# name op addr data expected (addr, data, expected in hex)
# expected: rdata for read, error flag for write, unused for pads and idle
rd_rst_cs0       read   00  00000000  00000000
rd_rst_sck       read   08  00000000  00000000
rd_rst_sda       read   20  00000000  00000000
pads_rst         pads   00  00000000  00000000
wr_cs1_gpio      write  04  00000001  00000000
pads_cs1_gpio    pads   00  00000000  00000000
rd_cs1           read   04  00000000  00000001
wr_scl_gpio      write  1c  ffffff01  00000000
rd_scl           read   1c  00000000  00000001
pads_two_gpio    pads   00  00000000  00000000
wr_sd2_code5     write  14  00000005  00000000
rd_sd2_code5     read   14  00000000  00000005
pads_code5       pads   00  00000000  00000000
wr_bad_index     write  24  00000001  00000001
wr_bad_align     write  06  00000001  00000001
rd_bad_index     read   fc  00000000  00000000
rd_bad_align     read   09  00000000  00000000
rd_cs1_kept      read   04  00000000  00000001
hb_idle          idle   00  00000020  00000000
wr_cs1_periph    write  04  00000000  00000000
pads_final       pads   00  00000000  00000000

// ==== bench/tb_fpga_pad_top.sv ====
// ************************************************************
// Pattern driven testbench; run from the project root so
// bench/pad_patterns.txt is found. Heartbeat width set to 5.
// ************************************************************

`timescale 1ns/1ps

module tb_fpga_pad_top
  import pad_pkg::*;
  import reg_bus_pkg::*;
();

  localparam int HB_WIDTH   = 5;
  localparam int SYNC_DEPTH = 2;

  logic      clk_gen;
  logic      rst_n;
  logic      reg_valid;
  logic      reg_write;
  reg_addr_t reg_addr;
  reg_data_t reg_wdata;
  reg_data_t reg_rdata;
  logic      reg_ready;
  logic      reg_error;
  pad_vec_t  periph_out;
  pad_vec_t  periph_oe;
  pad_vec_t  gpio_out;
  pad_vec_t  gpio_oe;
  pad_vec_t  pad_in;
  pad_vec_t  pad_out;
  pad_vec_t  pad_oe;
  pad_vec_t  periph_in;
  pad_vec_t  gpio_in;
  logic      clk_led;
  logic      rst_led;

  string     pat_name[$];
  string     pat_op[$];
  reg_addr_t pat_addr[$];
  reg_data_t pat_data[$];
  reg_data_t pat_exp[$];
  int        cycle_cnt   = 0;
  int        cycle_limit = 0;
  int        n_fail;

  fpga_pad_top #(
    .HEARTBEAT_WIDTH(HB_WIDTH),
    .RST_SYNC_STAGES(SYNC_DEPTH)
  ) i_dut (
    .clk_gen     (clk_gen),
    .rst_n       (rst_n),
    .reg_valid_i (reg_valid),
    .reg_write_i (reg_write),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_rdata_o (reg_rdata),
    .reg_ready_o (reg_ready),
    .reg_error_o (reg_error),
    .periph_out_i(periph_out),
    .periph_oe_i (periph_oe),
    .gpio_out_i  (gpio_out),
    .gpio_oe_i   (gpio_oe),
    .pad_in_i    (pad_in),
    .pad_out_o   (pad_out),
    .pad_oe_o    (pad_oe),
    .periph_in_o (periph_in),
    .gpio_in_o   (gpio_in),
    .clk_led_o   (clk_led),
    .rst_led_o   (rst_led)
  );

  pad_checker #(
    .HEARTBEAT_WIDTH(HB_WIDTH),
    .RST_SYNC_STAGES(SYNC_DEPTH)
  ) i_checker (
    .clk_gen     (clk_gen),
    .rst_n       (rst_n),
    .reg_valid_i (reg_valid),
    .reg_write_i (reg_write),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_rdata_i (reg_rdata),
    .reg_ready_i (reg_ready),
    .reg_error_i (reg_error),
    .periph_out_i(periph_out),
    .periph_oe_i (periph_oe),
    .gpio_out_i  (gpio_out),
    .gpio_oe_i   (gpio_oe),
    .pad_in_i    (pad_in),
    .pad_out_i   (pad_out),
    .pad_oe_i    (pad_oe),
    .periph_in_i (periph_in),
    .gpio_in_i   (gpio_in),
    .clk_led_i   (clk_led),
    .rst_led_i   (rst_led)
  );

  initial begin
    clk_gen = 1'b0;
    forever #5 clk_gen = ~clk_gen;
  end

  always @(posedge clk_gen) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic bit read_patterns();
    int        fd;
    int        cnt;
    string     line;
    string     name;
    string     op;
    reg_addr_t addr;
    reg_data_t data;
    reg_data_t exp;
    fd = $fopen("bench/pad_patterns.txt", "r");
    if (fd == 0) begin
      return 1'b0;
    end
    while ($fgets(line, fd) > 0) begin
      cnt = $sscanf(line, "%s %s %h %h %h", name, op, addr, data, exp);
      // Lines starting with # are comments
      if (cnt == 5 && name.getc(0) != "#") begin
        pat_name.push_back(name);
        pat_op.push_back(op);
        pat_addr.push_back(addr);
        pat_data.push_back(data);
        pat_exp.push_back(exp);
      end
    end
    $fclose(fd);
    return pat_name.size() > 0;
  endfunction

  task automatic release_reset();
    repeat (16) @(posedge clk_gen);
    rst_n <= 1'b1;
    while (!rst_led) @(posedge clk_gen);
    @(negedge clk_gen);
    i_checker.finish_test();
  endtask

  task automatic bus_access(input logic write, input reg_addr_t addr, input reg_data_t data);
    @(posedge clk_gen);
    reg_valid <= 1'b1;
    reg_write <= write;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge clk_gen);
    while (!reg_ready) @(posedge clk_gen);
    reg_valid <= 1'b0;
  endtask

  task automatic drive_random_pads();
    @(posedge clk_gen);
    periph_out <= pad_vec_t'($urandom);
    periph_oe  <= pad_vec_t'($urandom);
    gpio_out   <= pad_vec_t'($urandom);
    gpio_oe    <= pad_vec_t'($urandom);
    pad_in     <= pad_vec_t'($urandom);
    @(posedge clk_gen);
  endtask

  task automatic run_pattern(input int i);
    i_checker.start_test(pat_name[i], pat_exp[i]);
    if (pat_op[i] == "write") begin
      bus_access(1'b1, pat_addr[i], pat_data[i]);
    end else if (pat_op[i] == "read") begin
      bus_access(1'b0, pat_addr[i], pat_data[i]);
    end else if (pat_op[i] == "pads") begin
      drive_random_pads();
    end else if (pat_op[i] == "idle") begin
      repeat (pat_data[i]) @(posedge clk_gen);
    end else begin
      i_checker.note_text($sformatf("unknown operation %s in pattern file", pat_op[i]));
    end
    @(negedge clk_gen);
    i_checker.finish_test();
  endtask

  initial begin
    rst_n      = 1'b0;
    reg_valid  = 1'b0;
    reg_write  = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    periph_out = '0;
    periph_oe  = '0;
    gpio_out   = '0;
    gpio_oe    = '0;
    pad_in     = '0;
    void'($urandom(32'h6a748f1d));
    if (!read_patterns()) begin
      $display("Could not read any test from bench/pad_patterns.txt");
      $display("Verification failed");
      $finish;
    end else begin
      cycle_limit = 40 * pat_name.size() + 100;
      release_reset();
      for (int i = 0; i < pat_name.size(); i++) begin
        run_pattern(i);
      end
      i_checker.report_counts(n_fail);
      if (n_fail == 0) begin
        $display("Verification passed");
      end else begin
        $display("Verification failed");
      end
      $finish;
    end
  end

endmodule

// ==== fpga_pad_top.f ====
verilog/pad_pkg.sv
verilog/reg_bus_pkg.sv
verilog/reg_bus_if.sv
verilog/board_status.sv
verilog/pad_ctrl_regs.sv
verilog/pad_func_mux.sv
verilog/fpga_pad_top.sv
bench/pad_checker.sv
bench/tb_fpga_pad_top.sv

// ==== verilog/board_status.sv ====
// ************************************************************
// Reset synchronizer plus reset and heartbeat LEDs.
// RST_SYNC_STAGES must be at least 1.
// ************************************************************

`timescale 1ns/1ps

module board_status #(
  parameter int HEARTBEAT_WIDTH = 27,
  parameter int RST_SYNC_STAGES = 2
) (
  input  logic clk_gen,
  input  logic rst_n,
  output logic rst_sync_n_o,
  output logic clk_led_o,
  output logic rst_led_o
);

  typedef logic [HEARTBEAT_WIDTH-1:0] hb_cnt_t;

  logic [RST_SYNC_STAGES-1:0] sync_q;
  hb_cnt_t                    hb_cnt_q;

  // Async assert, synchronous release
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q[0] <= 1'b1;
      for (int i = 1; i < RST_SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign rst_sync_n_o = sync_q[RST_SYNC_STAGES-1];
  assign rst_led_o    = sync_q[RST_SYNC_STAGES-1];

  always_ff @(posedge clk_gen or negedge rst_sync_n_o) begin
    if (!rst_sync_n_o) begin
      hb_cnt_q <= '0;
    end else begin
      hb_cnt_q <= hb_cnt_q + 1'b1;
    end
  end

  assign clk_led_o = hb_cnt_q[HEARTBEAT_WIDTH-1];

  // Heartbeat restarts from zero on every reset
  a_hb_zero_in_reset : assert property (
    @(posedge clk_gen) !rst_sync_n_o |-> (hb_cnt_q == '0)
  );

endmodule

// ==== verilog/fpga_pad_top.sv ====
// ************************************************************
// Board-level pad logic around the MCU. Pads are split into
// separate in, out and oe ports; the MCU side is external.
// ************************************************************

`timescale 1ns/1ps

module fpga_pad_top
  import pad_pkg::*;
  import reg_bus_pkg::*;
#(
  parameter int HEARTBEAT_WIDTH = 27,
  parameter int RST_SYNC_STAGES = 2
) (
  input  logic      clk_gen,
  input  logic      rst_n,
  input  logic      reg_valid_i,
  input  logic      reg_write_i,
  input  reg_addr_t reg_addr_i,
  input  reg_data_t reg_wdata_i,
  output reg_data_t reg_rdata_o,
  output logic      reg_ready_o,
  output logic      reg_error_o,
  input  pad_vec_t  periph_out_i,
  input  pad_vec_t  periph_oe_i,
  input  pad_vec_t  gpio_out_i,
  input  pad_vec_t  gpio_oe_i,
  input  pad_vec_t  pad_in_i,
  output pad_vec_t  pad_out_o,
  output pad_vec_t  pad_oe_o,
  output pad_vec_t  periph_in_o,
  output pad_vec_t  gpio_in_o,
  output logic      clk_led_o,
  output logic      rst_led_o
);

  logic                            rst_sync_n;
  pad_mux_sel_t [NUM_MUX_PADS-1:0] pad_mux_sel;

  board_status #(
    .HEARTBEAT_WIDTH(HEARTBEAT_WIDTH),
    .RST_SYNC_STAGES(RST_SYNC_STAGES)
  ) i_board_status (
    .clk_gen     (clk_gen),
    .rst_n       (rst_n),
    .rst_sync_n_o(rst_sync_n),
    .clk_led_o   (clk_led_o),
    .rst_led_o   (rst_led_o)
  );

  reg_bus_if i_reg_bus ();

  assign i_reg_bus.valid = reg_valid_i;
  assign i_reg_bus.write = reg_write_i;
  assign i_reg_bus.addr  = reg_addr_i;
  assign i_reg_bus.wdata = reg_wdata_i;
  assign reg_rdata_o     = i_reg_bus.rdata;
  assign reg_ready_o     = i_reg_bus.ready;
  assign reg_error_o     = i_reg_bus.error;

  pad_ctrl_regs i_pad_ctrl_regs (
    .clk_gen      (clk_gen),
    .rst_n        (rst_sync_n),
    .bus          (i_reg_bus.responder),
    .pad_mux_sel_o(pad_mux_sel)
  );

  pad_func_mux i_pad_func_mux (
    .pad_mux_sel_i(pad_mux_sel),
    .periph_out_i (periph_out_i),
    .periph_oe_i  (periph_oe_i),
    .gpio_out_i   (gpio_out_i),
    .gpio_oe_i    (gpio_oe_i),
    .pad_in_i     (pad_in_i),
    .pad_out_o    (pad_out_o),
    .pad_oe_o     (pad_oe_o),
    .periph_in_o  (periph_in_o),
    .gpio_in_o    (gpio_in_o)
  );

endmodule

// ==== verilog/pad_ctrl_regs.sv ====
// ************************************************************
// Pad mux select registers, one per shared pad at 4*index.
// Bad or unaligned addresses answer with error, no write.
// ************************************************************

`timescale 1ns/1ps

module pad_ctrl_regs
  import pad_pkg::*;
  import reg_bus_pkg::*;
(
  input  logic                            clk_gen,
  input  logic                            rst_n,
  reg_bus_if.responder                    bus,
  output pad_mux_sel_t [NUM_MUX_PADS-1:0] pad_mux_sel_o
);

  typedef enum logic {
    REG_IDLE,
    REG_RESP
  } reg_state_e;

  reg_state_e                      state_q;
  pad_mux_sel_t [NUM_MUX_PADS-1:0] sel_q;
  reg_addr_t                       pad_idx;
  logic                            addr_ok;
  logic                            accept;
  logic                            err_q;
  reg_data_t                       rdata_q;
  pad_mux_sel_t                    rd_sel;

  // Address decode
  assign pad_idx = reg_addr_t'(bus.addr / REG_STRIDE);
  assign addr_ok = ((bus.addr % REG_STRIDE) == 0) && (int'(pad_idx) < NUM_MUX_PADS);
  assign accept  = (state_q == REG_IDLE) && bus.valid;

  always_comb begin
    rd_sel = PAD_FUNC_PERIPH;
    for (int k = 0; k < NUM_MUX_PADS; k++) begin
      if (int'(pad_idx) == k) begin
        rd_sel = sel_q[k];
      end
    end
  end

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= REG_IDLE;
      err_q   <= 1'b0;
      for (int k = 0; k < NUM_MUX_PADS; k++) begin
        sel_q[k] <= PAD_FUNC_PERIPH;
      end
    end else begin
      case (state_q)
        REG_IDLE: begin
          if (accept) begin
            state_q <= REG_RESP;
            err_q   <= !addr_ok;
            // Select changes on the edge that raises ready
            if (bus.write && addr_ok) begin
              for (int k = 0; k < NUM_MUX_PADS; k++) begin
                if (int'(pad_idx) == k) begin
                  sel_q[k] <= pad_mux_sel_t'(bus.wdata[PAD_SEL_W-1:0]);
                end
              end
            end
          end
        end
        REG_RESP: begin
          state_q <= REG_IDLE;
        end
        default: begin
          state_q <= REG_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_gen) begin
    if (accept) begin
      rdata_q <= (addr_ok && !bus.write) ? reg_data_t'(rd_sel) : '0;
    end
  end

  assign bus.ready     = (state_q == REG_RESP);
  assign bus.error     = bus.ready && err_q;
  assign bus.rdata     = rdata_q;
  assign pad_mux_sel_o = sel_q;

  a_ready_single : assert property (
    @(posedge clk_gen) disable iff (!rst_n) bus.ready |=> !bus.ready
  );

  a_ready_after_valid : assert property (
    @(posedge clk_gen) disable iff (!rst_n) bus.ready |-> $past(bus.valid)
  );

endmodule

// ==== verilog/pad_func_mux.sv ====
// ************************************************************
// Per-pad routing between peripheral and GPIO. Purely
// combinational; the unselected side reads zero.
// ************************************************************

`timescale 1ns/1ps

module pad_func_mux
  import pad_pkg::*;
(
  input  pad_mux_sel_t [NUM_MUX_PADS-1:0] pad_mux_sel_i,
  input  pad_vec_t                        periph_out_i,
  input  pad_vec_t                        periph_oe_i,
  input  pad_vec_t                        gpio_out_i,
  input  pad_vec_t                        gpio_oe_i,
  input  pad_vec_t                        pad_in_i,
  output pad_vec_t                        pad_out_o,
  output pad_vec_t                        pad_oe_o,
  output pad_vec_t                        periph_in_o,
  output pad_vec_t                        gpio_in_o
);

  always_comb begin
    for (int k = 0; k < NUM_MUX_PADS; k++) begin
      if (pad_mux_sel_i[k] == PAD_FUNC_GPIO) begin
        pad_out_o[k]   = gpio_out_i[k];
        pad_oe_o[k]    = gpio_oe_i[k];
        gpio_in_o[k]   = pad_in_i[k];
        periph_in_o[k] = 1'b0;
      end else begin
        // Peripheral, also for unknown codes
        pad_out_o[k]   = periph_out_i[k];
        pad_oe_o[k]    = periph_oe_i[k];
        periph_in_o[k] = pad_in_i[k];
        gpio_in_o[k]   = 1'b0;
      end
    end
  end

  // Input never reaches both consumers
  always_comb begin
    a_in_exclusive : assert final ((periph_in_o & gpio_in_o) == '0);
  end

endmodule

// ==== verilog/pad_pkg.sv ====
// ************************************************************
// Shared pad definitions. Pad indices match the select
// register order; unknown select codes act as peripheral.
// ************************************************************

package pad_pkg;

  localparam int NUM_MUX_PADS = 9;
  localparam int PAD_SEL_W    = 4;

  // One bit per shared pad
  typedef logic [NUM_MUX_PADS-1:0] pad_vec_t;

  typedef logic [PAD_SEL_W-1:0] pad_mux_sel_t;

  // Shared pad indices
  localparam int PAD_SPI2_CS_0 = 0;
  localparam int PAD_SPI2_CS_1 = 1;
  localparam int PAD_SPI2_SCK  = 2;
  localparam int PAD_SPI2_SD_0 = 3;
  localparam int PAD_SPI2_SD_1 = 4;
  localparam int PAD_SPI2_SD_2 = 5;
  localparam int PAD_SPI2_SD_3 = 6;
  localparam int PAD_I2C_SCL   = 7;
  localparam int PAD_I2C_SDA   = 8;

  // Function codes
  localparam pad_mux_sel_t PAD_FUNC_PERIPH = 4'd0;
  localparam pad_mux_sel_t PAD_FUNC_GPIO   = 4'd1;

endpackage

// ==== verilog/reg_bus_if.sv ====
// ************************************************************
// Simple request/response register bus. Requester holds the
// request until ready; ready lasts a single cycle.
// ************************************************************

`timescale 1ns/1ps

interface reg_bus_if
  import reg_bus_pkg::*;
();

  logic      valid;
  logic      write;
  reg_addr_t addr;
  reg_data_t wdata;
  reg_data_t rdata;
  logic      ready;
  logic      error;

  modport requester (
    output valid, write, addr, wdata,
    input  rdata, ready, error
  );

  modport responder (
    input  valid, write, addr, wdata,
    output rdata, ready, error
  );

endinterface

// ==== verilog/reg_bus_pkg.sv ====
// ************************************************************
// Register bus types. Byte addressed, one 32-bit register
// per stride, no byte enables.
// ************************************************************

package reg_bus_pkg;

  localparam int REG_ADDR_W = 8;
  localparam int REG_DATA_W = 32;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [REG_DATA_W-1:0] reg_data_t;

  // Byte distance between two select registers
  localparam int REG_STRIDE = 4;

endpackage
